/* verilog/icache_pkg.sv */
package icache_pkg;

	// ==================================================
	// Widths
	// ==================================================

	localparam int ADDR_W = 32;
	// One bus beat
	localparam int BEAT_W = 32;
	// One cache line, four beats
	localparam int LINE_W = 128;
	localparam int BEATS = LINE_W / BEAT_W;
	// Byte offset bits inside a line
	localparam int OFS_W = $clog2(LINE_W / 8);

	// ==================================================
	// Address map and fill pattern
	// ==================================================

	// Upper address half that selects the boot ROM
	localparam logic [15:0] ROM_BASE_HI = 16'hFFFF;
	// Filler for a faulted line
	localparam logic [BEAT_W-1:0] NOP_WORD = 32'h0000_00D2;

	// ==================================================
	// Encodings
	// ==================================================

	typedef enum logic [1:0] {
		F_NONE,
		F_BUS_ERR,
		F_EXEC_VIOL
	} fault_e;

	// Where the refilled line comes from
	typedef enum logic [1:0] {
		SRC_ROM,
		SRC_L2,
		SRC_BUS
	} src_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_WAIT_L2,
		S_BURST,
		S_FILL,
		S_SETTLE
	} refill_state_e;

endpackage

/* verilog/ic_refill_ctrl.sv */
`timescale 1ns/1ps

module ic_refill_ctrl #(
	parameter int ROM_RD_LAT = 1,
	parameter int L2_RD_LAT = 2,
	parameter int L1_WR_LAT = 2
) (
	input  logic clk,
	input  logic rst_i,
	input  logic fetch_valid_i,
	input  logic [icache_pkg::ADDR_W-1:0] fetch_adr_i,
	input  logic hit_i,
	input  logic inv_i,
	input  logic [icache_pkg::ADDR_W-1:0] inv_adr_i,
	input  logic l2_hit_i,
	input  logic ack_i,
	input  logic err_i,
	input  logic exv_i,
	output logic idle_o,
	output logic [icache_pkg::ADDR_W-1:0] l1_adr_o,
	output logic l1_wr_o,
	output logic l1_inv_o,
	output logic [icache_pkg::ADDR_W-1:0] l2_adr_o,
	output logic l2_ld_o,
	output icache_pkg::src_e src_sel_o,
	output logic beat_take_o,
	output logic [$clog2(icache_pkg::BEATS)-1:0] beat_idx_o,
	output logic fault_take_o,
	output icache_pkg::fault_e fault_code_o,
	output logic cyc_o,
	output logic stb_o,
	output logic [2:0] cti_o,
	output logic [icache_pkg::ADDR_W-1:0] adr_o,
	output logic [15:0] refill_cnt_o
);

	localparam int AW = icache_pkg::ADDR_W;
	localparam int OW = icache_pkg::OFS_W;
	localparam int BIDX_W = $clog2(icache_pkg::BEATS);
	// Longest wait any latency counter has to cover
	localparam int LAT_A = (ROM_RD_LAT > L2_RD_LAT) ? ROM_RD_LAT : L2_RD_LAT;
	localparam int LAT_MAX = (LAT_A > L1_WR_LAT) ? LAT_A : L1_WR_LAT;
	localparam int CNT_W = $clog2(LAT_MAX) + 1;

	icache_pkg::refill_state_e state;
	// Line-aligned address of the miss being served
	logic [AW-1:0] miss_adr;
	logic inv_pend;
	logic [AW-1:0] inv_adr_r;
	logic [CNT_W-1:0] lat_cnt;
	logic [BIDX_W-1:0] beat_cnt;
	logic is_rom;
	logic bus_fault;

	// ROM region comes from the latched miss, not the live fetch
	assign is_rom = (miss_adr[AW-1 -: 16] == icache_pkg::ROM_BASE_HI);
	assign bus_fault = err_i | exv_i;

	assign idle_o = (state == icache_pkg::S_IDLE);
	assign l2_adr_o = miss_adr;

	// Beat strobes are combinational so dat_i is taken in the answered cycle
	assign beat_take_o = (state == icache_pkg::S_BURST) & ack_i & ~bus_fault;
	assign beat_idx_o = beat_cnt;
	assign fault_take_o = (state == icache_pkg::S_BURST) & bus_fault;

	// Execute violation outranks a plain bus error
	always_comb begin
		if (exv_i)
			fault_code_o = icache_pkg::F_EXEC_VIOL;
		else if (err_i)
			fault_code_o = icache_pkg::F_BUS_ERR;
		else
			fault_code_o = icache_pkg::F_NONE;
	end

	// ==================================================
	// Refill sequencer
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= icache_pkg::S_IDLE;
			inv_pend <= 1'b0;
			lat_cnt <= '0;
			beat_cnt <= '0;
			l1_wr_o <= 1'b0;
			l1_inv_o <= 1'b0;
			l2_ld_o <= 1'b0;
			src_sel_o <= icache_pkg::SRC_ROM;
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			cti_o <= 3'b000;
			refill_cnt_o <= '0;
		end else begin
			// Strobes last a single cycle
			l1_wr_o <= 1'b0;
			l1_inv_o <= 1'b0;
			l2_ld_o <= 1'b0;
			case (state)
			icache_pkg::S_IDLE: begin
				lat_cnt <= '0;
				// Pending invalidate goes ahead of a new miss
				if (inv_pend) begin
					l1_adr_o <= {inv_adr_r[AW-1:OW], {OW{1'b0}}};
					l1_inv_o <= 1'b1;
					inv_pend <= 1'b0;
				end else if (fetch_valid_i && !hit_i) begin
					miss_adr <= {fetch_adr_i[AW-1:OW], {OW{1'b0}}};
					l1_adr_o <= {fetch_adr_i[AW-1:OW], {OW{1'b0}}};
					state <= icache_pkg::S_LOOKUP;
				end
			end
			icache_pkg::S_LOOKUP: begin
				lat_cnt <= lat_cnt + 1'b1;
				if (is_rom && lat_cnt == CNT_W'(ROM_RD_LAT - 1)) begin
					// ROM data is ready, write it next cycle
					src_sel_o <= icache_pkg::SRC_ROM;
					l1_wr_o <= 1'b1;
					lat_cnt <= '0;
					state <= icache_pkg::S_SETTLE;
				end else if (!is_rom && lat_cnt == CNT_W'(L2_RD_LAT - 1)) begin
					lat_cnt <= '0;
					state <= icache_pkg::S_WAIT_L2;
				end
			end
			icache_pkg::S_WAIT_L2: begin
				if (l2_hit_i) begin
					src_sel_o <= icache_pkg::SRC_L2;
					l1_wr_o <= 1'b1;
					state <= icache_pkg::S_SETTLE;
				end else begin
					// L2 miss, open the burst on the external bus
					src_sel_o <= icache_pkg::SRC_BUS;
					cyc_o <= 1'b1;
					stb_o <= 1'b1;
					cti_o <= 3'b001;
					adr_o <= miss_adr;
					beat_cnt <= '0;
					state <= icache_pkg::S_BURST;
				end
			end
			icache_pkg::S_BURST: begin
				if (bus_fault) begin
					// First fault ends the burst, line is not kept in L2
					cyc_o <= 1'b0;
					stb_o <= 1'b0;
					cti_o <= 3'b000;
					l1_wr_o <= 1'b1;
					state <= icache_pkg::S_FILL;
				end else if (ack_i) begin
					beat_cnt <= beat_cnt + 1'b1;
					// Flag the final beat
					if (beat_cnt == BIDX_W'(icache_pkg::BEATS - 2))
						cti_o <= 3'b111;
					if (beat_cnt == BIDX_W'(icache_pkg::BEATS - 1)) begin
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						cti_o <= 3'b000;
						l1_wr_o <= 1'b1;
						l2_ld_o <= 1'b1;
						state <= icache_pkg::S_FILL;
					end
				end
			end
			icache_pkg::S_FILL: begin
				// L1 write and L2 load happen during this cycle
				refill_cnt_o <= refill_cnt_o + 16'd1;
				lat_cnt <= '0;
				state <= icache_pkg::S_SETTLE;
			end
			icache_pkg::S_SETTLE: begin
				// Let the L1 write become visible before going idle
				lat_cnt <= lat_cnt + 1'b1;
				if (lat_cnt == CNT_W'(L1_WR_LAT - 1))
					state <= icache_pkg::S_IDLE;
			end
			default: state <= icache_pkg::S_IDLE;
			endcase
			// A new request overrides the clear done in S_IDLE
			if (inv_i) begin
				inv_pend <= 1'b1;
				inv_adr_r <= inv_adr_i;
			end
		end
	end

endmodule

/* verilog/ic_l1_array.sv */
`timescale 1ns/1ps

module ic_l1_array #(
	parameter int L1_LINES = 8
) (
	input  logic clk,
	input  logic rst_i,
	input  logic [icache_pkg::ADDR_W-1:0] rd_adr_i,
	input  logic [icache_pkg::ADDR_W-1:0] wr_adr_i,
	input  logic wr_i,
	input  logic inv_i,
	input  logic [icache_pkg::LINE_W-1:0] line_i,
	input  icache_pkg::fault_e fault_i,
	output logic hit_o,
	output logic [icache_pkg::LINE_W-1:0] line_o,
	output icache_pkg::fault_e fault_o
);

	localparam int OW = icache_pkg::OFS_W;
	localparam int IDX_W = $clog2(L1_LINES);
	localparam int TAG_W = icache_pkg::ADDR_W - OW - IDX_W;

	logic [TAG_W-1:0] tag_mem [L1_LINES];
	logic [icache_pkg::LINE_W-1:0] data_mem [L1_LINES];
	icache_pkg::fault_e fault_mem [L1_LINES];
	logic [L1_LINES-1:0] valid;

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] wr_idx;

	// Index sits just above the line offset
	assign rd_idx = rd_adr_i[OW +: IDX_W];
	assign rd_tag = rd_adr_i[icache_pkg::ADDR_W-1 -: TAG_W];
	assign wr_idx = wr_adr_i[OW +: IDX_W];

	// Lookup is purely combinational
	assign hit_o = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign line_o = data_mem[rd_idx];
	assign fault_o = fault_mem[rd_idx];

	// Valid bits
	always_ff @(posedge clk) begin
		if (rst_i)
			valid <= '0;
		else if (wr_i)
			valid[wr_idx] <= 1'b1;
		else if (inv_i)
			valid[wr_idx] <= 1'b0;
	end

	// Tag, fault code and data of a written line
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[wr_idx] <= wr_adr_i[icache_pkg::ADDR_W-1 -: TAG_W];
			data_mem[wr_idx] <= line_i;
			fault_mem[wr_idx] <= fault_i;
		end
	end

endmodule

/* verilog/ic_l2_array.sv */
`timescale 1ns/1ps

module ic_l2_array #(
	parameter int L2_LINES = 32
) (
	input  logic clk,
	input  logic rst_i,
	input  logic [icache_pkg::ADDR_W-1:0] adr_i,
	input  logic ld_i,
	input  logic [icache_pkg::LINE_W-1:0] line_i,
	output logic hit_o,
	output logic [icache_pkg::LINE_W-1:0] line_o
);

	localparam int OW = icache_pkg::OFS_W;
	localparam int IDX_W = $clog2(L2_LINES);
	localparam int TAG_W = icache_pkg::ADDR_W - OW - IDX_W;

	logic [TAG_W-1:0] tag_mem [L2_LINES];
	logic [icache_pkg::LINE_W-1:0] data_mem [L2_LINES];
	logic [L2_LINES-1:0] valid;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;

	assign idx = adr_i[OW +: IDX_W];
	assign tag = adr_i[icache_pkg::ADDR_W-1 -: TAG_W];

	// ==================================================
	// Valid bits and registered hit
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid <= '0;
			hit_o <= 1'b0;
		end else begin
			hit_o <= valid[idx] && (tag_mem[idx] == tag);
			if (ld_i)
				valid[idx] <= 1'b1;
		end
	end

	// Load replaces tag and data of the indexed entry
	always_ff @(posedge clk) begin
		line_o <= data_mem[idx];
		if (ld_i) begin
			tag_mem[idx] <= tag;
			data_mem[idx] <= line_i;
		end
	end

endmodule

/* verilog/ic_boot_rom.sv */
`timescale 1ns/1ps

module ic_boot_rom (
	input  logic clk,
	input  logic [icache_pkg::ADDR_W-1:0] adr_i,
	output logic [icache_pkg::LINE_W-1:0] line_o
);

	localparam int AW = icache_pkg::ADDR_W;
	localparam int OW = icache_pkg::OFS_W;
	localparam int BW = icache_pkg::BEAT_W;

	logic [AW-1:0] base;

	// Line-aligned start address
	assign base = {adr_i[AW-1:OW], {OW{1'b0}}};

	// Word k holds the inverse of its own byte address
	always_ff @(posedge clk) begin
		for (int k = 0; k < icache_pkg::BEATS; k++) begin
			line_o[k*BW +: BW] <= ~(base + AW'(4 * k));
		end
	end

endmodule

/* verilog/ic_line_assembler.sv */
`timescale 1ns/1ps

module ic_line_assembler (
	input  logic clk,
	input  icache_pkg::src_e src_sel_i,
	input  logic [icache_pkg::LINE_W-1:0] rom_line_i,
	input  logic [icache_pkg::LINE_W-1:0] l2_line_i,
	input  logic beat_take_i,
	input  logic [$clog2(icache_pkg::BEATS)-1:0] beat_idx_i,
	input  logic [icache_pkg::BEAT_W-1:0] dat_i,
	input  logic fault_take_i,
	input  icache_pkg::fault_e fault_code_i,
	output logic [icache_pkg::LINE_W-1:0] line_o,
	output icache_pkg::fault_e fault_o
);

	localparam int BW = icache_pkg::BEAT_W;

	// Line collected from the bus
	logic [icache_pkg::LINE_W-1:0] bus_line;
	icache_pkg::fault_e bus_fault;

	always_ff @(posedge clk) begin
		if (fault_take_i) begin
			// Whole line becomes NOPs tagged with the fault
			bus_line <= {icache_pkg::BEATS{icache_pkg::NOP_WORD}};
			bus_fault <= fault_code_i;
		end else if (beat_take_i) begin
			bus_line[beat_idx_i*BW +: BW] <= dat_i;
			// First beat starts a clean line
			if (beat_idx_i == '0)
				bus_fault <= icache_pkg::F_NONE;
		end
	end

	// Source select for the L1 and L2 write data
	always_comb begin
		case (src_sel_i)
		icache_pkg::SRC_ROM: begin
			line_o = rom_line_i;
			fault_o = icache_pkg::F_NONE;
		end
		icache_pkg::SRC_L2: begin
			line_o = l2_line_i;
			fault_o = icache_pkg::F_NONE;
		end
		default: begin
			line_o = bus_line;
			fault_o = bus_fault;
		end
		endcase
	end

endmodule

/* verilog/ic_subsystem_top.sv */
`timescale 1ns/1ps

module ic_subsystem_top #(
	parameter int L1_LINES = 8,
	parameter int L2_LINES = 32,
	parameter int ROM_RD_LAT = 1,
	parameter int L2_RD_LAT = 2,
	parameter int L1_WR_LAT = 2
) (
	input  logic clk,
	input  logic rst_i,
	input  logic fetch_valid_i,
	input  logic [icache_pkg::ADDR_W-1:0] fetch_adr_i,
	input  logic inv_i,
	input  logic [icache_pkg::ADDR_W-1:0] inv_adr_i,
	input  logic ack_i,
	input  logic err_i,
	input  logic exv_i,
	input  logic [icache_pkg::BEAT_W-1:0] dat_i,
	output logic hit_o,
	output logic [icache_pkg::LINE_W-1:0] line_o,
	output icache_pkg::fault_e fault_o,
	output logic idle_o,
	output logic [15:0] refill_cnt_o,
	output logic cyc_o,
	output logic stb_o,
	output logic [2:0] cti_o,
	output logic [icache_pkg::ADDR_W-1:0] adr_o
);

	// ==================================================
	// Internal nets
	// ==================================================

	logic [icache_pkg::ADDR_W-1:0] l1_adr;
	logic l1_wr;
	logic l1_inv;
	logic [icache_pkg::ADDR_W-1:0] l2_adr;
	logic l2_ld;
	logic l2_hit;
	logic [icache_pkg::LINE_W-1:0] l2_line;
	logic [icache_pkg::LINE_W-1:0] rom_line;
	// Assembled refill line
	logic [icache_pkg::LINE_W-1:0] fill_line;
	icache_pkg::fault_e fill_fault;
	icache_pkg::src_e src_sel;
	logic beat_take;
	logic [$clog2(icache_pkg::BEATS)-1:0] beat_idx;
	logic fault_take;
	icache_pkg::fault_e fault_code;

	ic_refill_ctrl #(
		.ROM_RD_LAT(ROM_RD_LAT),
		.L2_RD_LAT(L2_RD_LAT),
		.L1_WR_LAT(L1_WR_LAT)
	) u_ctrl (
		.clk(clk),
		.rst_i(rst_i),
		.fetch_valid_i(fetch_valid_i),
		.fetch_adr_i(fetch_adr_i),
		.hit_i(hit_o),
		.inv_i(inv_i),
		.inv_adr_i(inv_adr_i),
		.l2_hit_i(l2_hit),
		.ack_i(ack_i),
		.err_i(err_i),
		.exv_i(exv_i),
		.idle_o(idle_o),
		.l1_adr_o(l1_adr),
		.l1_wr_o(l1_wr),
		.l1_inv_o(l1_inv),
		.l2_adr_o(l2_adr),
		.l2_ld_o(l2_ld),
		.src_sel_o(src_sel),
		.beat_take_o(beat_take),
		.beat_idx_o(beat_idx),
		.fault_take_o(fault_take),
		.fault_code_o(fault_code),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.cti_o(cti_o),
		.adr_o(adr_o),
		.refill_cnt_o(refill_cnt_o)
	);

	// Fetch side looks up the live address
	ic_l1_array #(
		.L1_LINES(L1_LINES)
	) u_l1 (
		.clk(clk),
		.rst_i(rst_i),
		.rd_adr_i(fetch_adr_i),
		.wr_adr_i(l1_adr),
		.wr_i(l1_wr),
		.inv_i(l1_inv),
		.line_i(fill_line),
		.fault_i(fill_fault),
		.hit_o(hit_o),
		.line_o(line_o),
		.fault_o(fault_o)
	);

	ic_l2_array #(
		.L2_LINES(L2_LINES)
	) u_l2 (
		.clk(clk),
		.rst_i(rst_i),
		.adr_i(l2_adr),
		.ld_i(l2_ld),
		.line_i(fill_line),
		.hit_o(l2_hit),
		.line_o(l2_line)
	);

	// ROM reads the same latched miss address as the L2
	ic_boot_rom u_rom (
		.clk(clk),
		.adr_i(l2_adr),
		.line_o(rom_line)
	);

	ic_line_assembler u_asm (
		.clk(clk),
		.src_sel_i(src_sel),
		.rom_line_i(rom_line),
		.l2_line_i(l2_line),
		.beat_take_i(beat_take),
		.beat_idx_i(beat_idx),
		.dat_i(dat_i),
		.fault_take_i(fault_take),
		.fault_code_i(fault_code),
		.line_o(fill_line),
		.fault_o(fill_fault)
	);

endmodule

/* verification/ic_tb.sv */
`timescale 1ns/1ps

module ic_tb;

	// Worst bus refill in cycles, with fetch and invalidate overhead
	localparam int REFILL_MAX = 36;
	// 1 + 1 + 1 + 4 + 3 refills in the directed tests, plus the sweep
	localparam int SWEEP_N = 12;
	localparam int N_REFILLS = 10 + SWEEP_N;
	localparam int RESET_CYC = 10;
	localparam int TIMEOUT_CYC = RESET_CYC + 10 * REFILL_MAX * N_REFILLS;
	localparam logic [31:0] SEED = 32'h0334a013;

	logic clk = 1'b0;
	logic rst_i = 1'b1;
	logic fetch_valid_i = 1'b0;
	logic [31:0] fetch_adr_i = '0;
	logic inv_i = 1'b0;
	logic [31:0] inv_adr_i = '0;
	logic ack_i = 1'b0;
	logic err_i = 1'b0;
	logic exv_i = 1'b0;
	logic [31:0] dat_i = '0;
	logic hit_o;
	logic [127:0] line_o;
	icache_pkg::fault_e fault_o;
	logic idle_o;
	logic [15:0] refill_cnt_o;
	logic cyc_o;
	logic stb_o;
	logic [2:0] cti_o;
	logic [31:0] adr_o;

	// Separate LFSR streams for the slave and the sweep
	logic [31:0] slave_lfsr = SEED;
	logic [31:0] sweep_lfsr = SEED;
	logic [1:0] sl_beat = '0;
	logic [1:0] sl_wait = '0;
	int cycles = 0;
	int cyc_cycles = 0;
	int errors = 0;
	int test_errs = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	// Burst signal errors seen by the bus monitor
	int bus_errs = 0;
	int bus_errs_seen = 0;
	int bus_checks = 0;

	ic_subsystem_top #(
		.L1_LINES(8),
		.L2_LINES(32),
		.ROM_RD_LAT(1),
		.L2_RD_LAT(2),
		.L1_WR_LAT(2)
	) u_ic_subsystem_top (
		.clk(clk), .rst_i(rst_i),
		.fetch_valid_i(fetch_valid_i), .fetch_adr_i(fetch_adr_i),
		.inv_i(inv_i), .inv_adr_i(inv_adr_i),
		.ack_i(ack_i), .err_i(err_i), .exv_i(exv_i), .dat_i(dat_i),
		.hit_o(hit_o), .line_o(line_o), .fault_o(fault_o),
		.idle_o(idle_o), .refill_cnt_o(refill_cnt_o),
		.cyc_o(cyc_o), .stb_o(stb_o), .cti_o(cti_o), .adr_o(adr_o)
	);

	always #10 clk = ~clk;

	// ==================================================
	// Random source and reference model
	// ==================================================

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken, newest bit at the bottom
	task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v = {v[30:0], st[0]};
		end
	endtask

	// Expected L1 line and fault for any fetch address
	function automatic void expect_line(input logic [31:0] a, output logic [127:0] line,
		output icache_pkg::fault_e f);
		logic [31:0] base;
		logic [31:0] w;
		base = {a[31:4], 4'h0};
		f = icache_pkg::F_NONE;
		for (int k = 0; k < 4; k++) begin
			w = base + 32'(4 * k);
			if (base[31:16] == icache_pkg::ROM_BASE_HI)
				line[k*32 +: 32] = ~w;
			else
				line[k*32 +: 32] = {w[15:0], ~w[15:0]};
		end
		// Faults only come from the bus, never from ROM
		if (base[31:16] != icache_pkg::ROM_BASE_HI && (base[13] || base[12])) begin
			f = base[13] ? icache_pkg::F_EXEC_VIOL : icache_pkg::F_BUS_ERR;
			line = {4{icache_pkg::NOP_WORD}};
		end
	endfunction

	// ==================================================
	// Bus slave, monitor and watchdog
	// ==================================================

	always @(posedge clk) begin : bus_slave
		logic [31:0] bits;
		logic [31:0] badr;
		if (ack_i || err_i || exv_i) begin
			// Answer was taken on this edge
			ack_i <= 1'b0;
			err_i <= 1'b0;
			exv_i <= 1'b0;
			sl_beat <= sl_beat + 2'd1;
			draw_bits(slave_lfsr, 2, bits);
			sl_wait <= bits[1:0];
		end else if (cyc_o && stb_o) begin
			if (sl_wait != 2'd0) begin
				sl_wait <= sl_wait - 2'd1;
			end else begin
				badr = adr_o + {28'd0, sl_beat, 2'b00};
				dat_i <= {badr[15:0], ~badr[15:0]};
				if (sl_beat == 2'd0 && badr[13])
					exv_i <= 1'b1;
				else if (sl_beat == 2'd0 && badr[12])
					err_i <= 1'b1;
				else
					ack_i <= 1'b1;
			end
		end else begin
			sl_beat <= 2'd0;
		end
	end

	// Burst type and address at every answered beat, stb_o follows cyc_o
	always @(posedge clk) begin : bus_monitor
		logic [2:0] exp_cti;
		logic [31:0] exp_adr;
		exp_cti = (sl_beat == 2'd3) ? 3'b111 : 3'b001;
		exp_adr = {fetch_adr_i[31:4], 4'h0};
		if (!rst_i && (ack_i || err_i || exv_i)) begin
			bus_checks <= bus_checks + 1;
			if (!cyc_o || !stb_o || cti_o !== exp_cti || adr_o !== exp_adr) begin
				bus_errs <= bus_errs + 1;
				$display("[FAIL] %0t: beat %0d has cyc %b stb %b cti %b adr %h, %s %b adr %h",
					$time, sl_beat, cyc_o, stb_o, cti_o, adr_o, "expected cti",
					exp_cti, exp_adr);
			end
		end else if (!rst_i && stb_o !== cyc_o) begin
			bus_errs <= bus_errs + 1;
			$display("[FAIL] %0t: stb is %b while cyc is %b", $time, stb_o, cyc_o);
		end
	end

	// Cycles with a burst in flight
	always @(negedge clk) begin
		if (cyc_o)
			cyc_cycles <= cyc_cycles + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("Errors found");
			$finish;
		end
	end

	// ==================================================
	// Test helpers
	// ==================================================

	task automatic flag_error(input string msg);
		errors++;
		test_errs++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	task automatic finish_test(input string name);
		int n;
		tests++;
		n = test_errs + bus_errs - bus_errs_seen;
		bus_errs_seen = bus_errs;
		if (n == 0) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d error(s)", tests, name, n);
		end
		test_errs = 0;
	endtask

	// Pulse an invalidate, then wait for the line to stop hitting
	task automatic invalidate(input logic [31:0] a);
		int n;
		@(posedge clk);
		inv_i <= 1'b1;
		inv_adr_i <= a;
		fetch_valid_i <= 1'b0;
		fetch_adr_i <= a;
		@(posedge clk);
		inv_i <= 1'b0;
		n = 0;
		@(negedge clk);
		while (hit_o && n < 8) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (hit_o)
			flag_error($sformatf("line %h still hits after invalidate", a));
	endtask

	// Bus mode 0 expects no burst, 1 one bus refill, 2 either
	task automatic fetch_check(input logic [31:0] a, input int bus_mode);
		logic [127:0] exp_line;
		icache_pkg::fault_e exp_fault;
		int cyc0;
		logic [15:0] cnt0;
		expect_line(a, exp_line, exp_fault);
		cyc0 = cyc_cycles;
		cnt0 = refill_cnt_o;
		@(posedge clk);
		fetch_valid_i <= 1'b1;
		fetch_adr_i <= a;
		@(negedge clk);
		while (idle_o)
			@(negedge clk);
		while (!idle_o)
			@(negedge clk);
		checks += 3;
		if (!hit_o)
			flag_error($sformatf("no hit at %h after refill", a));
		if (line_o !== exp_line)
			flag_error($sformatf("line at %h is %h, expected %h", a, line_o, exp_line));
		if (fault_o !== exp_fault)
			flag_error($sformatf("fault at %h is %0d, expected %0d", a, fault_o, exp_fault));
		if (bus_mode == 0) begin
			checks++;
			if (cyc_cycles != cyc0 || refill_cnt_o != cnt0)
				flag_error($sformatf("unexpected bus refill for %h", a));
		end else if (bus_mode == 1) begin
			checks++;
			if (cyc_cycles == cyc0 || refill_cnt_o != cnt0 + 16'd1)
				flag_error($sformatf("missing bus refill for %h", a));
		end
		@(posedge clk);
		fetch_valid_i <= 1'b0;
		@(negedge clk);
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		logic [31:0] r;
		logic [31:0] lo;
		logic [31:0] a;
		int mode;
		int total_errs;
		repeat (RESET_CYC) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);

		fetch_check(32'h0000_0140, 1);
		finish_test("bus refill");

		fetch_check(32'hFFFF_0230, 0);
		finish_test("rom refill");

		// Line stays in the L2 after the L1 copy is dropped
		invalidate(32'h0000_0140);
		fetch_check(32'h0000_0140, 0);
		finish_test("l2 hit");

		// Same L1 index, different L2 index
		fetch_check(32'h0000_0200, 1);
		fetch_check(32'h0000_0280, 1);
		fetch_check(32'h0000_0200, 0);
		fetch_check(32'h0000_0280, 0);
		finish_test("eviction");

		fetch_check(32'h0000_1040, 1);
		fetch_check(32'h0000_2080, 1);
		invalidate(32'h0000_1040);
		fetch_check(32'h0000_1040, 1);
		finish_test("faults");

		for (int i = 0; i < SWEEP_N; i++) begin
			draw_bits(sweep_lfsr, 2, r);
			draw_bits(sweep_lfsr, 16, lo);
			case (r[1:0])
			2'd0: begin
				a = {16'hFFFF, lo[15:0]};
				mode = 0;
			end
			2'd1: begin
				a = {16'h0003, lo[15:0] | 16'h2000};
				mode = 1;
			end
			2'd2: begin
				a = {16'h0002, lo[15:0] | 16'h1000};
				mode = 1;
			end
			default: begin
				// Plain line may already sit in the L2
				a = {16'h0001, lo[15:0] & 16'hCFFF};
				mode = 2;
			end
			endcase
			invalidate(a);
			fetch_check(a, mode);
		end
		finish_test("random sweep");

		total_errs = errors + bus_errs;
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed, checks + bus_checks, total_errs);
		if (total_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* all.f */
verilog/icache_pkg.sv
verilog/ic_refill_ctrl.sv
verilog/ic_l1_array.sv
verilog/ic_l2_array.sv
verilog/ic_boot_rom.sv
verilog/ic_line_assembler.sv
verilog/ic_subsystem_top.sv
verification/ic_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module ic_tb -f all.f -o ic_sim \
	&& ./obj_dir/ic_sim | tee /dev/stderr | grep -qx "No errors" \
	|| exit 1
